/* pw_pkg.sv */
`default_nettype none

package pw_pkg;

  // ----------------------------------------
  // Tile sizes
  // ----------------------------------------
  localparam int CIN            = 32;
  localparam int COUT           = 32;
  localparam int ADDR_W         = 16;
  localparam int WORD_W         = 128;
  localparam int ACC_W          = 32;
  localparam int W_WORDS        = 64;
  localparam int ACT_FIFO_DEPTH = 8;

  // Layer control FSM states
  localparam logic [1:0] LC_IDLE  = 2'd0;
  localparam logic [1:0] LC_WLOAD = 2'd1;
  localparam logic [1:0] LC_RUN   = 2'd2;
  localparam logic [1:0] LC_DONE  = 2'd3;

  // Prefetch FSM states
  localparam logic [1:0] PF_IDLE  = 2'd0;
  localparam logic [1:0] PF_WAIT0 = 2'd1;
  localparam logic [1:0] PF_WAIT1 = 2'd2;
  localparam logic [1:0] PF_NEXT  = 2'd3;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------
  // Filled as two memory words, consumed one channel byte per step
  typedef union packed {
    logic [1:0][WORD_W-1:0] half;
    logic [CIN-1:0][7:0]    elem;
  } act_vec_t;

  typedef logic [COUT-1:0][7:0]      q_vec_t;
  typedef logic [COUT-1:0][ACC_W-1:0] acc_vec_t;

  // Two feature words per pixel, low channels first
  function automatic logic [ADDR_W-1:0] in_word_addr(input logic [ADDR_W-1:0] px,
                                                     input logic hsel);
    return {px[ADDR_W-2:0], hsel};
  endfunction

  function automatic logic [ADDR_W-1:0] out_word_addr(input logic [ADDR_W-1:0] px,
                                                      input logic hsel);
    return {px[ADDR_W-2:0], hsel};
  endfunction

endpackage

`default_nettype wire

/* pw_stage_if.sv */
`timescale 1ns/1ps
`default_nettype none

// ----------------------------------------
// MAC to requant
// ----------------------------------------
interface acc_if import pw_pkg::*; ();

  logic              valid;
  logic [ADDR_W-1:0] px;
  acc_vec_t          acc;
  logic              last;

  modport src (output valid, px, acc, last);
  modport dst (input valid, px, acc, last);

endinterface

// ----------------------------------------
// Requant to writeback
// ----------------------------------------
interface q_if import pw_pkg::*; ();

  logic              valid;
  logic [ADDR_W-1:0] px;
  q_vec_t            q;
  // Marks the final pixel of the run
  logic              last;

  modport src (output valid, px, q, last);
  modport dst (input valid, px, q, last);

endinterface

`default_nettype wire

/* layer_control.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_control import pw_pkg::*; (
  input  logic                   CLK,
  input  logic                   RESETn,
  input  logic                   start,
  input  logic [7:0]             img_w,
  input  logic [7:0]             img_h,
  input  logic [ADDR_W-1:0]      w_base_in,
  input  logic                   weight_valid,
  input  logic [WORD_W-1:0]      weight_data,
  input  logic                   weight_done,
  output logic                   weight_req,
  output logic [ADDR_W-1:0]      weight_base,
  output logic [ADDR_W:0]        weight_count,
  output logic                   run_start,
  output logic [ADDR_W-1:0]      total_px,
  input  logic [$clog2(CIN)-1:0] wt_k,
  output logic [COUT*8-1:0]      wt_col,
  input  logic                   run_end,
  output logic                   done
);

  logic [1:0]                 state;
  logic [$clog2(W_WORDS)-1:0] beat;

  // One 256-bit column of lane weights per step
  logic [1:0][WORD_W-1:0] bank [CIN];

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETn) begin
      state      <= LC_IDLE;
      weight_req <= 1'b0;
      beat       <= '0;
    end else begin
      weight_req <= 1'b0;
      case (state)
        LC_IDLE: begin
          if (start) begin
            weight_req <= 1'b1;
            beat       <= '0;
            state      <= LC_WLOAD;
          end
        end
        LC_WLOAD: begin
          if (weight_valid) begin
            beat <= beat + 1'b1;
          end
          if (weight_done) begin
            state <= LC_RUN;
          end
        end
        LC_RUN: begin
          if (run_end) begin
            state <= LC_DONE;
          end
        end
        // Done state lasts a single cycle
        default: state <= LC_IDLE;
      endcase
    end
  end

  // Request fields and image size latched with the accepted start
  always_ff @(posedge CLK) begin
    if (state == LC_IDLE && start) begin
      weight_base  <= w_base_in;
      weight_count <= (ADDR_W+1)'(W_WORDS);
      total_px     <= img_w * img_h;
    end
  end

  // ----------------------------------------
  // Weight bank
  // ----------------------------------------
  // Even beats fill lanes 0..15, odd beats lanes 16..31
  always_ff @(posedge CLK) begin
    if (state == LC_WLOAD && weight_valid) begin
      bank[beat[$clog2(W_WORDS)-1:1]][beat[0]] <= weight_data;
    end
  end

  assign wt_col = bank[wt_k];

  // Prefetch launches on the cycle the stream ends
  assign run_start = (state == LC_WLOAD) && weight_done;
  assign done      = (state == LC_DONE);

endmodule

`default_nettype wire

/* act_prefetch.sv */
`timescale 1ns/1ps
`default_nettype none

module act_prefetch import pw_pkg::*; (
  input  logic              CLK,
  input  logic              RESETn,
  input  logic              run_start,
  input  logic [ADDR_W-1:0] total_px,
  input  logic              feat_rd_valid,
  input  logic [WORD_W-1:0] feat_rd_data,
  output logic              feat_rd_en,
  output logic [ADDR_W-1:0] feat_rd_addr,
  input  logic              act_ready,
  output logic              act_valid,
  output logic [ADDR_W-1:0] act_px,
  output act_vec_t          act_vec,
  output logic              act_last
);

  localparam int FIFO_AW = $clog2(ACT_FIFO_DEPTH);

  logic [1:0]        state;
  logic [ADDR_W-1:0] px_cnt;
  logic [WORD_W-1:0] low_half;

  logic              push;
  logic              push_last;
  act_vec_t          push_vec;
  logic              pop;

  act_vec_t          vec_mem  [ACT_FIFO_DEPTH];
  logic [ADDR_W-1:0] px_mem   [ACT_FIFO_DEPTH];
  logic              last_mem [ACT_FIFO_DEPTH];
  logic [FIFO_AW-1:0] wptr;
  logic [FIFO_AW-1:0] rptr;
  logic [FIFO_AW:0]   count;
  logic               full;

  // ----------------------------------------
  // Read sequencer
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETn) begin
      state      <= PF_IDLE;
      px_cnt     <= '0;
      feat_rd_en <= 1'b0;
    end else begin
      feat_rd_en <= 1'b0;
      case (state)
        PF_IDLE: begin
          if (run_start) begin
            px_cnt       <= '0;
            feat_rd_en   <= 1'b1;
            feat_rd_addr <= in_word_addr('0, 1'b0);
            state        <= PF_WAIT0;
          end
        end
        PF_WAIT0: begin
          if (feat_rd_valid) begin
            low_half     <= feat_rd_data;
            feat_rd_en   <= 1'b1;
            feat_rd_addr <= in_word_addr(px_cnt, 1'b1);
            state        <= PF_WAIT1;
          end
        end
        PF_WAIT1: begin
          if (feat_rd_valid) begin
            px_cnt <= px_cnt + 1'b1;
            state  <= push_last ? PF_IDLE : PF_NEXT;
          end
        end
        default: begin
          // Hold off while the FIFO has no room
          if (!full) begin
            feat_rd_en   <= 1'b1;
            feat_rd_addr <= in_word_addr(px_cnt, 1'b0);
            state        <= PF_WAIT0;
          end
        end
      endcase
    end
  end

  always_comb begin
    push_vec.half[0] = low_half;
    push_vec.half[1] = feat_rd_data;
  end

  assign push      = (state == PF_WAIT1) && feat_rd_valid;
  assign push_last = (px_cnt == total_px - 1'b1);

  // ----------------------------------------
  // Activation FIFO
  // ----------------------------------------
  assign full      = (count == ACT_FIFO_DEPTH);
  assign act_valid = (count != '0);
  assign pop       = act_valid && act_ready;

  always_ff @(posedge CLK) begin
    if (push) begin
      vec_mem[wptr]  <= push_vec;
      px_mem[wptr]   <= px_cnt;
      last_mem[wptr] <= push_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      count <= count + push - pop;
    end
  end

  assign act_vec  = vec_mem[rptr];
  assign act_px   = px_mem[rptr];
  assign act_last = last_mem[rptr];

endmodule

`default_nettype wire

/* mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_array import pw_pkg::*; (
  input  logic                   CLK,
  input  logic                   RESETn,
  input  logic [COUT*ACC_W-1:0]  bias_vec,
  input  logic                   act_valid,
  input  logic [ADDR_W-1:0]      act_px,
  input  act_vec_t               act_vec,
  input  logic                   act_last,
  output logic                   act_ready,
  output logic [$clog2(CIN)-1:0] wt_k,
  input  logic [COUT*8-1:0]      wt_col,
  acc_if.src                     acc_bus
);

  logic                   busy;
  logic [$clog2(CIN)-1:0] k;
  logic                   pop;
  logic                   out_valid;

  act_vec_t               vec_r;
  logic [ADDR_W-1:0]      px_r;
  logic                   last_r;
  acc_vec_t               acc_r;

  logic signed [7:0]      a_k;
  logic signed [15:0]     prod [COUT];

  assign act_ready = !busy;
  assign pop       = act_valid && act_ready;
  assign wt_k      = k;

  // ----------------------------------------
  // Step control
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETn) begin
      busy      <= 1'b0;
      k         <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= 1'b0;
      if (pop) begin
        busy <= 1'b1;
        k    <= '0;
      end else if (busy) begin
        k <= k + 1'b1;
        if (k == CIN - 1) begin
          busy      <= 1'b0;
          out_valid <= 1'b1;
        end
      end
    end
  end

  // One input channel per step, broadcast to all lanes
  assign a_k = vec_r.elem[k];

  always_comb begin
    for (int i = 0; i < COUT; i++) begin
      prod[i] = a_k * $signed(wt_col[8*i +: 8]);
    end
  end

  // Accumulators start from the lane bias
  always_ff @(posedge CLK) begin
    if (pop) begin
      vec_r  <= act_vec;
      px_r   <= act_px;
      last_r <= act_last;
      for (int i = 0; i < COUT; i++) begin
        acc_r[i] <= bias_vec[ACC_W*i +: ACC_W];
      end
    end else if (busy) begin
      for (int i = 0; i < COUT; i++) begin
        acc_r[i] <= $signed(acc_r[i]) + prod[i];
      end
    end
  end

  assign acc_bus.valid = out_valid;
  assign acc_bus.px    = px_r;
  assign acc_bus.acc   = acc_r;
  assign acc_bus.last  = last_r;

endmodule

`default_nettype wire

/* requant.sv */
`timescale 1ns/1ps
`default_nettype none

module requant import pw_pkg::*; (
  input  logic               CLK,
  input  logic               RESETn,
  input  logic signed [15:0] quant_M,
  input  logic [5:0]         quant_s,
  input  logic signed [7:0]  quant_zp,
  acc_if.dst                 acc_bus,
  q_if.src                   q_bus
);

  logic signed [ACC_W+15:0] prod_r [COUT];
  logic                     v1;
  logic                     v2;
  logic [ADDR_W-1:0]        px1;
  logic [ADDR_W-1:0]        px2;
  logic                     last1;
  logic                     last2;
  q_vec_t                   q_r;

  // Clamp to the int8 range
  function automatic logic [7:0] sat8(input logic signed [ACC_W+15:0] v);
    if (v > 127) begin
      return 8'h7f;
    end else if (v < -128) begin
      return 8'h80;
    end
    return v[7:0];
  endfunction

  always_ff @(posedge CLK) begin
    if (!RESETn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= acc_bus.valid;
      v2 <= v1;
    end
  end

  // ----------------------------------------
  // Stage 1, scale
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    px1   <= acc_bus.px;
    last1 <= acc_bus.last;
    for (int i = 0; i < COUT; i++) begin
      prod_r[i] <= $signed(acc_bus.acc[i]) * quant_M;
    end
  end

  // ----------------------------------------
  // Stage 2, shift, offset and clamp
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    px2   <= px1;
    last2 <= last1;
    for (int i = 0; i < COUT; i++) begin
      q_r[i] <= sat8((prod_r[i] >>> quant_s) + quant_zp);
    end
  end

  assign q_bus.valid = v2;
  assign q_bus.px    = px2;
  assign q_bus.q     = q_r;
  assign q_bus.last  = last2;

endmodule

`default_nettype wire

/* writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback import pw_pkg::*; (
  input  logic              CLK,
  input  logic              RESETn,
  q_if.dst                  q_bus,
  output logic              feat_wr_en,
  output logic [ADDR_W-1:0] feat_wr_addr,
  output logic [WORD_W-1:0] feat_wr_data,
  output logic              run_end
);

  logic              hi_phase;
  logic              last_wr;
  logic [WORD_W-1:0] hi_r;
  logic [ADDR_W-1:0] px_r;
  logic              last_r;

  always_ff @(posedge CLK) begin
    if (!RESETn) begin
      feat_wr_en <= 1'b0;
      hi_phase   <= 1'b0;
      last_wr    <= 1'b0;
      run_end    <= 1'b0;
    end else begin
      feat_wr_en <= 1'b0;
      last_wr    <= 1'b0;
      run_end    <= last_wr;
      if (q_bus.valid) begin
        feat_wr_en <= 1'b1;
        hi_phase   <= 1'b1;
      end else if (hi_phase) begin
        // Upper half goes out next
        feat_wr_en <= 1'b1;
        hi_phase   <= 1'b0;
        last_wr    <= last_r;
      end
    end
  end

  // Low channels to 2*px, high channels to 2*px+1
  always_ff @(posedge CLK) begin
    if (q_bus.valid) begin
      hi_r         <= q_bus.q[COUT-1:COUT/2];
      px_r         <= q_bus.px;
      last_r       <= q_bus.last;
      feat_wr_addr <= out_word_addr(q_bus.px, 1'b0);
      feat_wr_data <= q_bus.q[COUT/2-1:0];
    end else if (hi_phase) begin
      feat_wr_addr <= out_word_addr(px_r, 1'b1);
      feat_wr_data <= hi_r;
    end
  end

endmodule

`default_nettype wire

/* pw_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pw_top import pw_pkg::*; (
  input  logic                  CLK,
  input  logic                  RESETn,
  input  logic                  start,
  output logic                  done,
  input  logic [7:0]            img_w,
  input  logic [7:0]            img_h,
  input  logic [ADDR_W-1:0]     w_base_in,
  input  logic signed [15:0]    quant_M,
  input  logic [5:0]            quant_s,
  input  logic signed [7:0]     quant_zp,
  input  logic [COUT*ACC_W-1:0] bias_vec,
  // Weight stream
  output logic                  weight_req,
  output logic [ADDR_W-1:0]     weight_base,
  output logic [ADDR_W:0]       weight_count,
  input  logic                  weight_valid,
  input  logic [WORD_W-1:0]     weight_data,
  input  logic                  weight_done,
  // Feature memory
  output logic                  feat_rd_en,
  output logic [ADDR_W-1:0]     feat_rd_addr,
  input  logic [WORD_W-1:0]     feat_rd_data,
  input  logic                  feat_rd_valid,
  output logic                  feat_wr_en,
  output logic [ADDR_W-1:0]     feat_wr_addr,
  output logic [WORD_W-1:0]     feat_wr_data
);

  logic                   run_start;
  logic [ADDR_W-1:0]      total_px;
  logic [$clog2(CIN)-1:0] wt_k;
  logic [COUT*8-1:0]      wt_col;
  logic                   run_end;

  logic                   act_valid;
  logic                   act_ready;
  logic [ADDR_W-1:0]      act_px;
  act_vec_t               act_vec;
  logic                   act_last;

  acc_if acc_link ();
  q_if   q_link ();

  layer_control u_ctrl (
    .CLK          (CLK),
    .RESETn       (RESETn),
    .start        (start),
    .img_w        (img_w),
    .img_h        (img_h),
    .w_base_in    (w_base_in),
    .weight_valid (weight_valid),
    .weight_data  (weight_data),
    .weight_done  (weight_done),
    .weight_req   (weight_req),
    .weight_base  (weight_base),
    .weight_count (weight_count),
    .run_start    (run_start),
    .total_px     (total_px),
    .wt_k         (wt_k),
    .wt_col       (wt_col),
    .run_end      (run_end),
    .done         (done)
  );

  act_prefetch u_prefetch (
    .CLK           (CLK),
    .RESETn        (RESETn),
    .run_start     (run_start),
    .total_px      (total_px),
    .feat_rd_valid (feat_rd_valid),
    .feat_rd_data  (feat_rd_data),
    .feat_rd_en    (feat_rd_en),
    .feat_rd_addr  (feat_rd_addr),
    .act_ready     (act_ready),
    .act_valid     (act_valid),
    .act_px        (act_px),
    .act_vec       (act_vec),
    .act_last      (act_last)
  );

  mac_array u_mac (
    .CLK       (CLK),
    .RESETn    (RESETn),
    .bias_vec  (bias_vec),
    .act_valid (act_valid),
    .act_px    (act_px),
    .act_vec   (act_vec),
    .act_last  (act_last),
    .act_ready (act_ready),
    .wt_k      (wt_k),
    .wt_col    (wt_col),
    .acc_bus   (acc_link)
  );

  requant u_requant (
    .CLK      (CLK),
    .RESETn   (RESETn),
    .quant_M  (quant_M),
    .quant_s  (quant_s),
    .quant_zp (quant_zp),
    .acc_bus  (acc_link),
    .q_bus    (q_link)
  );

  writeback u_wb (
    .CLK          (CLK),
    .RESETn       (RESETn),
    .q_bus        (q_link),
    .feat_wr_en   (feat_wr_en),
    .feat_wr_addr (feat_wr_addr),
    .feat_wr_data (feat_wr_data),
    .run_end      (run_end)
  );

endmodule

`default_nettype wire

/* tb_pw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pw import pw_pkg::*; ();

  // Pixels summed over all runs
  localparam int TOTAL_PX = 15 + 15 + 6 + 1;

  logic                  CLK;
  logic                  RESETn;
  logic                  start;
  logic                  done;
  logic [7:0]            img_w;
  logic [7:0]            img_h;
  logic [ADDR_W-1:0]     w_base_in;
  logic signed [15:0]    quant_M;
  logic [5:0]            quant_s;
  logic signed [7:0]     quant_zp;
  logic [COUT*ACC_W-1:0] bias_vec;
  logic                  weight_req;
  logic [ADDR_W-1:0]     weight_base;
  logic [ADDR_W:0]       weight_count;
  logic                  weight_valid;
  logic [WORD_W-1:0]     weight_data;
  logic                  weight_done;
  logic                  feat_rd_en;
  logic [ADDR_W-1:0]     feat_rd_addr;
  logic [WORD_W-1:0]     feat_rd_data;
  logic                  feat_rd_valid;
  logic                  feat_wr_en;
  logic [ADDR_W-1:0]     feat_wr_addr;
  logic [WORD_W-1:0]     feat_wr_data;

  // Memory contents for the current run
  logic [WORD_W-1:0] wt_words [W_WORDS];
  logic [WORD_W-1:0] fmem [64];
  int                wr_cnt [64];

  int unsigned rng     = 42;
  int unsigned lat_rng = 42;
  int          errors  = 0;
  int          cyc     = 0;
  int          npx     = 0;
  int          n_wr    = 0;
  int          n_done  = 0;
  int          n_wreq  = 0;
  int          n_sat_hi = 0;
  int          n_sat_lo = 0;
  int          exp_rd_addr = 0;
  int          last_wr_cyc = 0;
  int          rd_wait = 0;
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] cur_base;

  pw_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic int unsigned lcg_step(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int unsigned next_rand();
    rng = lcg_step(rng);
    return rng;
  endfunction

  // Built from the upper LCG bits
  function automatic logic [WORD_W-1:0] rand_word();
    logic [WORD_W-1:0] w;
    for (int n = 0; n < 8; n++) begin
      w[16*n +: 16] = next_rand() >> 16;
    end
    return w;
  endfunction

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                          $time, name, got, exp));
    end
  endtask

  // Bias plus dot product, scale, shift, offset, clamp
  function automatic logic [COUT*8-1:0] ref_pixel(input int px);
    logic [COUT*8-1:0] q;
    int                acc;
    longint            p;
    byte               a;
    byte               w;
    for (int i = 0; i < COUT; i++) begin
      acc = $signed(bias_vec[ACC_W*i +: ACC_W]);
      for (int k = 0; k < CIN; k++) begin
        a   = fmem[2*px + k/16][8*(k%16) +: 8];
        w   = wt_words[2*k + i/16][8*(i%16) +: 8];
        acc = acc + a * w;
      end
      p = longint'(acc) * longint'(quant_M);
      p = (p >>> quant_s) + quant_zp;
      if (p > 127) begin
        q[8*i +: 8] = 8'h7f;
      end else if (p < -128) begin
        q[8*i +: 8] = 8'h80;
      end else begin
        q[8*i +: 8] = p[7:0];
      end
    end
    return q;
  endfunction

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  initial begin : weight_model
    forever begin
      @(negedge CLK);
      if (weight_req === 1'b1) begin
        for (int j = 0; j < W_WORDS; j++) begin
          @(negedge CLK);
          weight_valid = 1'b1;
          weight_data  = wt_words[j];
        end
        @(negedge CLK);
        weight_valid = 1'b0;
        weight_done  = 1'b1;
        @(negedge CLK);
        weight_done  = 1'b0;
      end
    end
  end

  // Read latency of 1 to 4 cycles
  always @(negedge CLK) begin : feat_read_model
    feat_rd_valid = 1'b0;
    if (rd_wait > 0) begin
      rd_wait--;
      if (rd_wait == 0) begin
        feat_rd_valid = 1'b1;
        feat_rd_data  = fmem[rd_addr];
      end
    end
    if (feat_rd_en === 1'b1) begin
      rd_addr = feat_rd_addr;
      lat_rng = lcg_step(lat_rng);
      rd_wait = 1 + lat_rng[17:16];
    end
  end

  // ----------------------------------------
  // Output monitor and compare
  // ----------------------------------------
  always @(negedge CLK) begin : output_monitor
    logic [COUT*8-1:0] exp_vec;
    cyc++;
    if (RESETn) begin
      if (weight_req) begin
        n_wreq++;
        check_val("weight_base", weight_base, cur_base);
        check_val("weight_count", weight_count, W_WORDS);
      end
      if (feat_rd_en) begin
        check_val("feat_rd_addr", feat_rd_addr, exp_rd_addr);
        exp_rd_addr++;
      end
      if (feat_wr_en) begin
        if (feat_wr_addr >= 2 * npx) begin
          abort_run($sformatf("write to address %0d is outside the image", feat_wr_addr));
        end
        if (wr_cnt[feat_wr_addr] != 0) begin
          abort_run($sformatf("address %0d was written more than once", feat_wr_addr));
        end
        wr_cnt[feat_wr_addr]++;
        exp_vec = ref_pixel(feat_wr_addr >> 1);
        check_val("feat_wr_data", feat_wr_data,
                  feat_wr_addr[0] ? exp_vec[255:128] : exp_vec[127:0]);
        for (int b = 0; b < 16; b++) begin
          if (feat_wr_data[8*b +: 8] == 8'h7f) begin
            n_sat_hi++;
          end
          if (feat_wr_data[8*b +: 8] == 8'h80) begin
            n_sat_lo++;
          end
        end
        n_wr++;
        last_wr_cyc = cyc;
      end
      if (done) begin
        n_done++;
        check_val("writes before done", n_wr, 2 * npx);
        check_val("done delay", cyc - last_wr_cyc, 2);
      end
    end
  end

  // ----------------------------------------
  // One run of the engine
  // ----------------------------------------
  task automatic run_image(input int w, input int h, input int base, input int m,
                           input int s, input int zp, input bit poke, input bit sat);
    logic [31:0] r;
    for (int j = 0; j < W_WORDS; j++) begin
      wt_words[j] = rand_word();
    end
    for (int a = 0; a < 64; a++) begin
      fmem[a]   = rand_word();
      wr_cnt[a] = 0;
    end
    for (int i = 0; i < COUT; i++) begin
      r = next_rand() >> 8;
      bias_vec[ACC_W*i +: ACC_W] = {{20{r[11]}}, r[11:0]};
    end
    img_w     = w;
    img_h     = h;
    w_base_in = base;
    cur_base  = base;
    quant_M   = m;
    quant_s   = s;
    quant_zp  = zp;
    npx       = w * h;
    n_wr      = 0;
    n_done    = 0;
    n_wreq    = 0;
    n_sat_hi  = 0;
    n_sat_lo  = 0;
    exp_rd_addr = 0;

    @(negedge CLK);
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    check_val("weight_req", weight_req, 1);

    // A start in the middle of the run must be ignored
    if (poke) begin
      while (n_wr < 4) @(posedge CLK);
      @(negedge CLK);
      start = 1'b1;
      @(negedge CLK);
      start = 1'b0;
    end

    while (n_done == 0) @(posedge CLK);
    repeat (20) @(negedge CLK);

    check_val("done pulses", n_done, 1);
    check_val("weight requests", n_wreq, 1);
    check_val("feature reads", exp_rd_addr, 2 * npx);
    check_val("feature writes", n_wr, 2 * npx);
    if (sat) begin
      check_val("bytes clamped to 127", n_sat_hi != 0, 1);
      check_val("bytes clamped to -128", n_sat_lo != 0, 1);
    end
  endtask

  initial begin : watchdog
    repeat (60 * TOTAL_PX + 2000 + 16) @(posedge CLK);
    abort_run("watchdog expired before the tests finished");
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_seq
    RESETn        = 1'b0;
    start         = 1'b0;
    img_w         = '0;
    img_h         = '0;
    w_base_in     = '0;
    cur_base      = '0;
    quant_M       = '0;
    quant_s       = '0;
    quant_zp      = '0;
    bias_vec      = '0;
    weight_valid  = 1'b0;
    weight_data   = '0;
    weight_done   = 1'b0;
    feat_rd_valid = 1'b0;
    feat_rd_data  = '0;

    repeat (16) @(negedge CLK);
    check_val("done", done, 0);
    check_val("weight_req", weight_req, 0);
    check_val("feat_rd_en", feat_rd_en, 0);
    check_val("feat_wr_en", feat_wr_en, 0);
    RESETn = 1'b1;
    repeat (4) @(negedge CLK);

    // Moderate scale, then both saturation directions, then a single pixel
    run_image(5, 3, 16'h0100, 33, 14, 5, 1'b1, 1'b0);
    run_image(5, 3, 16'h0200, 32767, 0, 0, 1'b0, 1'b1);
    run_image(3, 2, 16'h0300, -32768, 0, -3, 1'b0, 1'b1);
    run_image(1, 1, 16'h0400, 21, 13, -2, 1'b0, 1'b0);

    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
pw_pkg.sv
pw_stage_if.sv
layer_control.sv
act_prefetch.sv
mac_array.sv
requant.sv
writeback.sv
pw_top.sv
tb_pw.sv

/* Bender.yml */
package:
  name: pw_conv

sources:
  - pw_pkg.sv
  - pw_stage_if.sv
  - layer_control.sv
  - act_prefetch.sv
  - mac_array.sv
  - requant.sv
  - writeback.sv
  - pw_top.sv
  - target: simulation
    files:
      - tb_pw.sv
